// ==== source/wb_pkg.sv ====
package wb_pkg;

  // datapath and pc width
  localparam int xlen = 32;

  // general register index
  localparam int gpr_addr_w = 5;

  // full csr number as carried by the execute lanes
  localparam int csr_addr_w = 14;

  // implemented csr slots
  localparam int csr_count = 8;

  // combinational gpr read ports for the earlier stages
  localparam int read_ports = 4;

  // implemented csr numbers, entry 0 is the lowest slot
  // anything not listed here reads zero and drops writes
  localparam logic [csr_count-1:0][csr_addr_w-1:0] csr_table = {
    14'h181,
    14'h180,
    14'h044,
    14'h041,
    14'h040,
    14'h030,
    14'h007,
    14'h000
  };

  // forwarding record, msb first:
  // valid[0], gr_we, dest, result, csr_we, csr_addr, csr_wdata
  localparam int fwd_w = 1 + 1 + gpr_addr_w + xlen + 1 + csr_addr_w + xlen;

  // one lane's committed register write
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic                  we;
    logic [gpr_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } gpr_commit_t;

  // the single csr write that left the stage
  typedef struct packed {
    logic                  we;
    logic [csr_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } csr_commit_t;

  // flat widths of the trace records at the top level
  localparam int gpr_commit_w = $bits(gpr_commit_t);
  localparam int csr_commit_w = $bits(csr_commit_t);

endpackage

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
  // lane 1, the older instruction
  input  logic [1:0]                    lane_1_valid,
  input  logic                          lane_1_gr_we,
  input  logic [wb_pkg::gpr_addr_w-1:0] lane_1_dest,
  input  logic [wb_pkg::xlen-1:0]       lane_1_result,
  input  logic                          lane_1_csr_we,
  input  logic [wb_pkg::csr_addr_w-1:0] lane_1_csr_addr,
  input  logic [wb_pkg::xlen-1:0]       lane_1_csr_wdata,
  // lane 2, the younger instruction
  input  logic [1:0]                    lane_2_valid,
  input  logic                          lane_2_gr_we,
  input  logic [wb_pkg::gpr_addr_w-1:0] lane_2_dest,
  input  logic [wb_pkg::xlen-1:0]       lane_2_result,
  input  logic                          lane_2_csr_we,
  input  logic [wb_pkg::csr_addr_w-1:0] lane_2_csr_addr,
  input  logic [wb_pkg::xlen-1:0]       lane_2_csr_wdata,
  input  logic                          nblock1,
  input  logic                          nblock2,
  output logic                          ws_ready,
  output logic [wb_pkg::fwd_w-1:0]      forward_data1,
  output logic [wb_pkg::fwd_w-1:0]      forward_data2,
  // register file write ports
  output logic                          rf_we1,
  output logic [wb_pkg::gpr_addr_w-1:0] rf_waddr1,
  output logic [wb_pkg::xlen-1:0]       rf_wdata1,
  output logic                          rf_we2,
  output logic [wb_pkg::gpr_addr_w-1:0] rf_waddr2,
  output logic [wb_pkg::xlen-1:0]       rf_wdata2,
  // csr write port
  output logic                          csr_we,
  output logic [wb_pkg::csr_addr_w-1:0] csr_addr,
  output logic [wb_pkg::xlen-1:0]       csr_wdata
);

  logic lane_1_live;
  logic lane_2_live;
  logic same_dest;

  // a lane commits only with both valid bits up
  assign lane_1_live = &lane_1_valid;
  assign lane_2_live = &lane_2_valid;

  // upstream stall report only, nothing here waits on it
  assign ws_ready = nblock1 & nblock2;

  // bypass records go out even for lanes that are not live
  assign forward_data1 = {lane_1_valid[0], lane_1_gr_we, lane_1_dest, lane_1_result,
                          lane_1_csr_we, lane_1_csr_addr, lane_1_csr_wdata};
  assign forward_data2 = {lane_2_valid[0], lane_2_gr_we, lane_2_dest, lane_2_result,
                          lane_2_csr_we, lane_2_csr_addr, lane_2_csr_wdata};

  assign same_dest = (lane_1_dest == lane_2_dest);

  // younger lane owns a shared destination
  assign rf_we2    = lane_2_gr_we & lane_2_live;
  assign rf_waddr2 = lane_2_dest;
  assign rf_wdata2 = lane_2_result;

  assign rf_we1    = lane_1_gr_we & lane_1_live & ~(rf_we2 & same_dest);
  assign rf_waddr1 = lane_1_dest;
  assign rf_wdata1 = lane_1_result;

  // one csr writer per cycle, program order
  always_comb begin
    if (lane_1_live && lane_1_csr_we) begin
      csr_we    = 1'b1;
      csr_addr  = lane_1_csr_addr;
      csr_wdata = lane_1_csr_wdata;
    end else if (lane_1_live && lane_2_live && lane_2_csr_we) begin
      // lane 2 only lands behind a live lane 1
      csr_we    = 1'b1;
      csr_addr  = lane_2_csr_addr;
      csr_wdata = lane_2_csr_wdata;
    end else begin
      csr_we    = 1'b0;
      csr_addr  = '0;
      csr_wdata = '0;
    end
  end

endmodule

// ==== source/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file (
  input  logic                          clk,
  input  logic                          reset,
  // write port 1, older lane
  input  logic                          rf_we1,
  input  logic [wb_pkg::gpr_addr_w-1:0] rf_waddr1,
  input  logic [wb_pkg::xlen-1:0]       rf_wdata1,
  // write port 2, younger lane
  input  logic                          rf_we2,
  input  logic [wb_pkg::gpr_addr_w-1:0] rf_waddr2,
  input  logic [wb_pkg::xlen-1:0]       rf_wdata2,
  // combinational reads
  input  logic [wb_pkg::gpr_addr_w-1:0] rd_addr [wb_pkg::read_ports],
  output logic [wb_pkg::xlen-1:0]       rd_data [wb_pkg::read_ports]
);

  import wb_pkg::*;

  logic [xlen-1:0] regs [2**gpr_addr_w];
  logic            wr1_ok;
  logic            wr2_ok;

  // r0 is never written
  assign wr1_ok = rf_we1 && (rf_waddr1 != '0);
  assign wr2_ok = rf_we2 && (rf_waddr2 != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**gpr_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr1_ok) begin
        regs[rf_waddr1] <= rf_wdata1;
      end
      // port 2 after port 1, so it wins a shared index
      if (wr2_ok) begin
        regs[rf_waddr2] <= rf_wdata2;
      end
    end
  end

  // stored contents only, bypass is done upstream
  always_comb begin
    for (int p = 0; p < read_ports; p++) begin
      if (rd_addr[p] == '0) begin
        rd_data[p] = '0;
      end else begin
        rd_data[p] = regs[rd_addr[p]];
      end
    end
  end

endmodule

// ==== source/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
  input  logic                          clk,
  input  logic                          reset,
  // write port from the writeback arbiter
  input  logic                          csr_we,
  input  logic [wb_pkg::csr_addr_w-1:0] csr_addr,
  input  logic [wb_pkg::xlen-1:0]       csr_wdata,
  // same-cycle read port
  input  logic [wb_pkg::csr_addr_w-1:0] csr_rd_addr,
  output logic [wb_pkg::xlen-1:0]       csr_rd_data
);

  import wb_pkg::*;

  logic [xlen-1:0]      slots [csr_count];
  logic [csr_count-1:0] wr_hit;
  logic [csr_count-1:0] rd_hit;

  // one-hot slot match against the address table
  function automatic logic [csr_count-1:0] slot_match(
    input logic [csr_addr_w-1:0] addr
  );
    logic [csr_count-1:0] hit;
    for (int i = 0; i < csr_count; i++) begin
      hit[i] = (addr == csr_table[i]);
    end
    return hit;
  endfunction

  assign wr_hit = slot_match(csr_addr);
  assign rd_hit = slot_match(csr_rd_addr);

  // unmatched writes fall through with no slot selected
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < csr_count; i++) begin
        slots[i] <= '0;
      end
    end else if (csr_we) begin
      for (int i = 0; i < csr_count; i++) begin
        if (wr_hit[i]) begin
          slots[i] <= csr_wdata;
        end
      end
    end
  end

  // table entries are distinct, at most one hit
  always_comb begin
    csr_rd_data = '0;
    for (int i = 0; i < csr_count; i++) begin
      if (rd_hit[i]) begin
        csr_rd_data = slots[i];
      end
    end
  end

endmodule

// ==== source/commit_trace.sv ====
`timescale 1ns/1ps

module commit_trace #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t d,
  output payload_t q
);

  // one stage of delay for the difftest compare
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

// ==== source/wb_subsystem.sv ====
`timescale 1ns/1ps

module wb_subsystem (
  input  logic                            clk,
  input  logic                            reset,
  // lane 1, the older instruction
  input  logic [1:0]                      lane_1_valid,
  input  logic                            lane_1_gr_we,
  input  logic [wb_pkg::gpr_addr_w-1:0]   lane_1_dest,
  input  logic [wb_pkg::xlen-1:0]         lane_1_result,
  input  logic [wb_pkg::xlen-1:0]         lane_1_pc,
  input  logic                            lane_1_csr_we,
  input  logic [wb_pkg::csr_addr_w-1:0]   lane_1_csr_addr,
  input  logic [wb_pkg::xlen-1:0]         lane_1_csr_wdata,
  // lane 2, the younger instruction
  input  logic [1:0]                      lane_2_valid,
  input  logic                            lane_2_gr_we,
  input  logic [wb_pkg::gpr_addr_w-1:0]   lane_2_dest,
  input  logic [wb_pkg::xlen-1:0]         lane_2_result,
  input  logic [wb_pkg::xlen-1:0]         lane_2_pc,
  input  logic                            lane_2_csr_we,
  input  logic [wb_pkg::csr_addr_w-1:0]   lane_2_csr_addr,
  input  logic [wb_pkg::xlen-1:0]         lane_2_csr_wdata,
  input  logic                            nblock1,
  input  logic                            nblock2,
  input  logic [wb_pkg::gpr_addr_w-1:0]   rd_addr [wb_pkg::read_ports],
  input  logic [wb_pkg::csr_addr_w-1:0]   csr_rd_addr,
  output logic                            ws_ready,
  output logic [wb_pkg::fwd_w-1:0]        forward_data1,
  output logic [wb_pkg::fwd_w-1:0]        forward_data2,
  output logic [wb_pkg::xlen-1:0]         rd_data [wb_pkg::read_ports],
  output logic [wb_pkg::xlen-1:0]         csr_rd_data,
  // registered commit records
  output logic [wb_pkg::gpr_commit_w-1:0] trace_lane1,
  output logic [wb_pkg::gpr_commit_w-1:0] trace_lane2,
  output logic [wb_pkg::csr_commit_w-1:0] trace_csr
);

  import wb_pkg::*;

  logic                  rf_we1;
  logic [gpr_addr_w-1:0] rf_waddr1;
  logic [xlen-1:0]       rf_wdata1;
  logic                  rf_we2;
  logic [gpr_addr_w-1:0] rf_waddr2;
  logic [xlen-1:0]       rf_wdata2;
  logic                  csr_we;
  logic [csr_addr_w-1:0] csr_addr;
  logic [xlen-1:0]       csr_wdata;

  gpr_commit_t lane1_rec;
  gpr_commit_t lane2_rec;
  csr_commit_t csr_rec;

  writeback_stage i_writeback_stage (
    .lane_1_valid     (lane_1_valid),
    .lane_1_gr_we     (lane_1_gr_we),
    .lane_1_dest      (lane_1_dest),
    .lane_1_result    (lane_1_result),
    .lane_1_csr_we    (lane_1_csr_we),
    .lane_1_csr_addr  (lane_1_csr_addr),
    .lane_1_csr_wdata (lane_1_csr_wdata),
    .lane_2_valid     (lane_2_valid),
    .lane_2_gr_we     (lane_2_gr_we),
    .lane_2_dest      (lane_2_dest),
    .lane_2_result    (lane_2_result),
    .lane_2_csr_we    (lane_2_csr_we),
    .lane_2_csr_addr  (lane_2_csr_addr),
    .lane_2_csr_wdata (lane_2_csr_wdata),
    .nblock1          (nblock1),
    .nblock2          (nblock2),
    .ws_ready         (ws_ready),
    .forward_data1    (forward_data1),
    .forward_data2    (forward_data2),
    .rf_we1           (rf_we1),
    .rf_waddr1        (rf_waddr1),
    .rf_wdata1        (rf_wdata1),
    .rf_we2           (rf_we2),
    .rf_waddr2        (rf_waddr2),
    .rf_wdata2        (rf_wdata2),
    .csr_we           (csr_we),
    .csr_addr         (csr_addr),
    .csr_wdata        (csr_wdata)
  );

  gpr_file i_gpr_file (
    .clk       (clk),
    .reset     (reset),
    .rf_we1    (rf_we1),
    .rf_waddr1 (rf_waddr1),
    .rf_wdata1 (rf_wdata1),
    .rf_we2    (rf_we2),
    .rf_waddr2 (rf_waddr2),
    .rf_wdata2 (rf_wdata2),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  csr_file i_csr_file (
    .clk         (clk),
    .reset       (reset),
    .csr_we      (csr_we),
    .csr_addr    (csr_addr),
    .csr_wdata   (csr_wdata),
    .csr_rd_addr (csr_rd_addr),
    .csr_rd_data (csr_rd_data)
  );

  // trace carries the arbitrated writes, not the raw lane fields
  assign lane1_rec = '{pc: lane_1_pc, we: rf_we1, addr: rf_waddr1, data: rf_wdata1};
  assign lane2_rec = '{pc: lane_2_pc, we: rf_we2, addr: rf_waddr2, data: rf_wdata2};
  assign csr_rec   = '{we: csr_we, addr: csr_addr, data: csr_wdata};

  commit_trace #(.payload_t(gpr_commit_t)) i_trace_lane1 (
    .clk   (clk),
    .reset (reset),
    .d     (lane1_rec),
    .q     (trace_lane1)
  );

  commit_trace #(.payload_t(gpr_commit_t)) i_trace_lane2 (
    .clk   (clk),
    .reset (reset),
    .d     (lane2_rec),
    .q     (trace_lane2)
  );

  commit_trace #(.payload_t(csr_commit_t)) i_trace_csr (
    .clk   (clk),
    .reset (reset),
    .d     (csr_rec),
    .q     (trace_csr)
  );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int half_period = 10;
  localparam int reset_cycles = 10;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // released a little after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

// ==== bench/wb_subsystem_tb.sv ====
`timescale 1ns/1ps

module wb_subsystem_tb;

  import wb_pkg::*;

  localparam int random_cycles = 400;
  // random part, directed part and a margin
  localparam int cycle_limit = random_cycles + 50 + 100;

  logic                    clk;
  logic                    reset;
  logic [1:0]              lane_1_valid = '0;
  logic                    lane_1_gr_we = 1'b0;
  logic [gpr_addr_w-1:0]   lane_1_dest = '0;
  logic [xlen-1:0]         lane_1_result = '0;
  logic [xlen-1:0]         lane_1_pc = '0;
  logic                    lane_1_csr_we = 1'b0;
  logic [csr_addr_w-1:0]   lane_1_csr_addr = '0;
  logic [xlen-1:0]         lane_1_csr_wdata = '0;
  logic [1:0]              lane_2_valid = '0;
  logic                    lane_2_gr_we = 1'b0;
  logic [gpr_addr_w-1:0]   lane_2_dest = '0;
  logic [xlen-1:0]         lane_2_result = '0;
  logic [xlen-1:0]         lane_2_pc = '0;
  logic                    lane_2_csr_we = 1'b0;
  logic [csr_addr_w-1:0]   lane_2_csr_addr = '0;
  logic [xlen-1:0]         lane_2_csr_wdata = '0;
  logic                    nblock1 = 1'b0;
  logic                    nblock2 = 1'b0;
  logic [gpr_addr_w-1:0]   rd_addr [read_ports] = '{default: '0};
  logic [csr_addr_w-1:0]   csr_rd_addr = '0;
  logic                    ws_ready;
  logic [fwd_w-1:0]        forward_data1;
  logic [fwd_w-1:0]        forward_data2;
  logic [xlen-1:0]         rd_data [read_ports];
  logic [xlen-1:0]         csr_rd_data;
  logic [gpr_commit_w-1:0] trace_lane1;
  logic [gpr_commit_w-1:0] trace_lane2;
  logic [csr_commit_w-1:0] trace_csr;

  // reference state where r0 is never written
  logic [xlen-1:0] shadow_gpr [2**gpr_addr_w] = '{default: '0};
  logic [xlen-1:0] shadow_csr [2**csr_addr_w] = '{default: '0};
  gpr_commit_t     exp_lane1 = '0;
  gpr_commit_t     exp_lane2 = '0;
  csr_commit_t     exp_csr = '0;
  logic [xlen-1:0] shared_value;
  logic [31:0]     rng_state = 32'h662f;
  int              errors = 0;
  int              checks = 0;
  int              cycle_count = 0;

  tb_clock i_tb_clock (
    .clk   (clk),
    .reset (reset)
  );

  wb_subsystem i_wb_subsystem (.*);

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic csr_present(input logic [csr_addr_w-1:0] addr);
    case (addr)
      14'h000, 14'h007, 14'h030, 14'h040, 14'h041, 14'h044, 14'h180, 14'h181: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // mostly implemented numbers with an occasional arbitrary one
  function automatic logic [csr_addr_w-1:0] pick_csr_addr(input logic [31:0] r);
    logic [csr_addr_w-1:0] known [8];
    known = '{14'h000, 14'h007, 14'h030, 14'h040, 14'h041, 14'h044, 14'h180, 14'h181};
    if (r[31:30] == 2'b00) begin
      return r[29:16];
    end
    return known[r[29:27]];
  endfunction

  task automatic check_equal(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    end
  endtask

  // mid-cycle compare against contents before this cycle's writes
  task automatic check_outputs();
    check_equal("ws_ready", 128'(nblock1 & nblock2), 128'(ws_ready));
    check_equal("forward_data1", 128'({lane_1_valid[0], lane_1_gr_we, lane_1_dest,
                lane_1_result, lane_1_csr_we, lane_1_csr_addr, lane_1_csr_wdata}),
                128'(forward_data1));
    check_equal("forward_data2", 128'({lane_2_valid[0], lane_2_gr_we, lane_2_dest,
                lane_2_result, lane_2_csr_we, lane_2_csr_addr, lane_2_csr_wdata}),
                128'(forward_data2));
    for (int p = 0; p < read_ports; p++) begin
      check_equal($sformatf("rd_data[%0d]", p), 128'(shadow_gpr[rd_addr[p]]),
                  128'(rd_data[p]));
    end
    check_equal("csr_rd_data",
                128'(csr_present(csr_rd_addr) ? shadow_csr[csr_rd_addr] : 32'd0),
                128'(csr_rd_data));
    check_equal("trace_lane1", 128'(exp_lane1), 128'(trace_lane1));
    check_equal("trace_lane2", 128'(exp_lane2), 128'(trace_lane2));
    check_equal("trace_csr", 128'(exp_csr), 128'(trace_csr));
  endtask

  task automatic update_model();
    logic live1;
    logic live2;
    logic we1;
    logic we2;
    live1 = &lane_1_valid;
    live2 = &lane_2_valid;
    we2 = live2 && lane_2_gr_we;
    // younger lane owns a shared destination
    we1 = live1 && lane_1_gr_we && !(we2 && lane_1_dest == lane_2_dest);
    exp_lane1 = '{pc: lane_1_pc, we: we1, addr: lane_1_dest, data: lane_1_result};
    exp_lane2 = '{pc: lane_2_pc, we: we2, addr: lane_2_dest, data: lane_2_result};
    if (we1 && lane_1_dest != '0) begin
      shadow_gpr[lane_1_dest] = lane_1_result;
    end
    if (we2 && lane_2_dest != '0) begin
      shadow_gpr[lane_2_dest] = lane_2_result;
    end
    if (live1 && lane_1_csr_we) begin
      exp_csr = '{we: 1'b1, addr: lane_1_csr_addr, data: lane_1_csr_wdata};
    end else if (live1 && live2 && lane_2_csr_we) begin
      exp_csr = '{we: 1'b1, addr: lane_2_csr_addr, data: lane_2_csr_wdata};
    end else begin
      exp_csr = '0;
    end
    if (exp_csr.we && csr_present(exp_csr.addr)) begin
      shadow_csr[exp_csr.addr] = exp_csr.data;
    end
  endtask

  // biased commit pair with reads aimed at last cycle's targets
  task automatic randomize_inputs();
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] u;
    r = next_random();
    s = next_random();
    u = next_random();
    rd_addr[0] = lane_1_dest;
    rd_addr[1] = lane_2_dest;
    rd_addr[2] = u[31:27];
    rd_addr[3] = u[26:22];
    csr_rd_addr = r[13] ? lane_1_csr_addr : lane_2_csr_addr;
    lane_1_valid = (r[31:30] != 2'b00) ? 2'b11 : r[29:28];
    lane_2_valid = (r[27:26] != 2'b00) ? 2'b11 : r[25:24];
    lane_1_gr_we = r[23] | r[22];
    lane_2_gr_we = r[21] | r[20];
    lane_1_csr_we = r[19];
    lane_2_csr_we = r[18];
    nblock1 = r[17] | r[16];
    nblock2 = r[15] | r[14];
    lane_1_dest = s[31:27];
    lane_2_dest = (s[21:20] == 2'b00) ? s[31:27] : s[26:22];
    lane_1_csr_addr = pick_csr_addr(next_random());
    lane_2_csr_addr = (s[19:18] == 2'b00) ? lane_1_csr_addr : pick_csr_addr(next_random());
    lane_1_result = next_random();
    lane_2_result = next_random();
    lane_1_pc = next_random();
    lane_2_pc = next_random();
    lane_1_csr_wdata = next_random();
    lane_2_csr_wdata = next_random();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic settle_and_check();
    #8;
    check_outputs();
    update_model();
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
        $display("timeout: run still going after %0d cycles", cycle_count);
        $display("test failed");
        $finish;
      end
    end
  end

  initial begin
    wait (reset === 1'b1);
    wait (reset === 1'b0);
    #8;
    // traces and both files start out cleared
    check_equal("trace_csr after reset", 128'(0), 128'(trace_csr));
    check_outputs();
    update_model();
    repeat (random_cycles) begin
      next_cycle();
      randomize_inputs();
      settle_and_check();
    end
    // both live lanes on one destination
    next_cycle();
    randomize_inputs();
    lane_1_valid = 2'b11;
    lane_2_valid = 2'b11;
    lane_1_gr_we = 1'b1;
    lane_2_gr_we = 1'b1;
    lane_1_dest = 5'd9;
    lane_2_dest = 5'd9;
    shared_value = lane_2_result;
    settle_and_check();
    next_cycle();
    randomize_inputs();
    settle_and_check();
    check_equal("rd_data[0] after shared write", 128'(shared_value), 128'(rd_data[0]));
    // write to a csr number outside the table
    next_cycle();
    randomize_inputs();
    lane_1_valid = 2'b11;
    lane_1_csr_we = 1'b1;
    lane_1_csr_addr = 14'h123;
    settle_and_check();
    next_cycle();
    randomize_inputs();
    csr_rd_addr = 14'h123;
    settle_and_check();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== wb_subsystem.f ====
source/wb_pkg.sv
source/writeback_stage.sv
source/gpr_file.sv
source/csr_file.sv
source/commit_trace.sv
source/wb_subsystem.sv
bench/tb_clock.sv
bench/wb_subsystem_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = wb_subsystem_tb
FILELIST  = wb_subsystem.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the log holds the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
